// File: hdl/opn_pkg.sv
// FM chip timer core shared types, register map and timing constants
package opn_pkg;

    // Register numbers decoded by the timer core
    typedef enum logic [7:0] {
        REG_TIMER_A_HI = 8'h24,     // Timer A bits 9:2
        REG_TIMER_A_LO = 8'h25,     // Timer A bits 1:0
        REG_TIMER_B    = 8'h26,
        REG_TIMER_CTL  = 8'h27      // Load, enable and clear bits
    } opn_reg_e;

    // Write state of the CPU bus
    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } bus_state_e;

    // Bit positions inside the control register
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;
    localparam int CTL_EN_B   = 3;
    localparam int CTL_CLR_A  = 4;  // Write-only, not stored
    localparam int CTL_CLR_B  = 5;

    // Timer widths
    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;

    // Timebase
    localparam int PRESCALE    = 6;     // cen cycles per internal clock enable
    localparam int SLOTS       = 24;    // 6 channels x 4 operators
    localparam int TIMER_B_DIV = 16;    // Sample ticks per timer B step

    // cen cycles that busy stays up after a data write
    localparam int BUSY_CYCLES = 32;

    // Status byte layout
    localparam int STATUS_BUSY   = 7;
    localparam int STATUS_FLAG_B = 1;
    localparam int STATUS_FLAG_A = 0;

endpackage

// File: hdl/opn_timer_if.sv
`timescale 1ns/1ps
// Timer settings from the register decoder and overflow flags back from the timers
interface opn_timer_if (
    input logic clk
);

    // Timer reload values
    logic [opn_pkg::TIMER_A_W-1:0] value_a;
    logic [opn_pkg::TIMER_B_W-1:0] value_b;

    // Control levels
    logic load_a;
    logic load_b;
    logic en_a;     // Flag A gating
    logic en_b;

    // One-cycle clear pulses
    logic clr_a;
    logic clr_b;

    // Overflow flags
    logic flag_a;
    logic flag_b;

    modport decode (input clk, output value_a, value_b, load_a, load_b,
                    en_a, en_b, clr_a, clr_b);

    modport timers (input clk, input value_a, value_b, load_a, load_b,
                    en_a, en_b, clr_a, clr_b, output flag_a, flag_b);

    // Read-only view for the status byte
    modport status (input flag_a, flag_b);

endinterface

// File: hdl/opn_reg_decode.sv
`timescale 1ns/1ps
// CPU bus decoder with address latch, timer registers and write-busy counter
module opn_reg_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  din,
    input  logic [1:0]  addr,
    input  logic        cs_n,
    input  logic        wr_n,
    output logic        busy,
    opn_timer_if.decode tmr
);

    typedef logic [$clog2(opn_pkg::BUSY_CYCLES)-1:0] busy_cnt_t;

    opn_pkg::bus_state_e state;
    busy_cnt_t           busy_cnt;
    logic [7:0]          reg_sel;   // Latched register number
    logic                write;
    logic                addr_wr;
    logic                data_wr;
    logic                ctl_wr;

    // addr[1] selects nothing in this core
    assign write   = ~cs_n & ~wr_n & cen;
    assign addr_wr = write & ~addr[0];
    assign data_wr = write & addr[0] & (state == opn_pkg::IDLE);   // Dropped while busy
    assign ctl_wr  = data_wr & (reg_sel == opn_pkg::REG_TIMER_CTL);

    assign busy = (state == opn_pkg::BUSY);

    // Address phase is always accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_sel <= 8'h00;
        end else if (addr_wr) begin
            reg_sel <= din;
        end
    end

    // Busy FSM, counts cen-high cycles after each data write
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= opn_pkg::IDLE;
            busy_cnt <= '0;
        end else begin
            case (state)
                opn_pkg::IDLE: begin
                    if (data_wr) begin
                        state    <= opn_pkg::BUSY;
                        busy_cnt <= '0;
                    end
                end
                opn_pkg::BUSY: begin
                    if (cen) begin
                        busy_cnt <= busy_cnt + 1'b1;
                        if (busy_cnt == busy_cnt_t'(opn_pkg::BUSY_CYCLES - 1)) begin
                            state <= opn_pkg::IDLE;
                        end
                    end
                end
                default: state <= opn_pkg::IDLE;
            endcase
        end
    end

    // Timer reload values
    always_ff @(posedge clk) begin
        if (data_wr) begin
            case (reg_sel)
                opn_pkg::REG_TIMER_A_HI: tmr.value_a[opn_pkg::TIMER_A_W-1:2] <= din;
                opn_pkg::REG_TIMER_A_LO: tmr.value_a[1:0] <= din[1:0];
                opn_pkg::REG_TIMER_B:    tmr.value_b <= din;
                default: ;
            endcase
        end
    end

    // Control register, clear bits only pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            tmr.load_a <= 1'b0;
            tmr.load_b <= 1'b0;
            tmr.en_a   <= 1'b0;
            tmr.en_b   <= 1'b0;
            tmr.clr_a  <= 1'b0;
            tmr.clr_b  <= 1'b0;
        end else begin
            tmr.clr_a <= 1'b0;
            tmr.clr_b <= 1'b0;
            if (ctl_wr) begin
                tmr.load_a <= din[opn_pkg::CTL_LOAD_A];
                tmr.load_b <= din[opn_pkg::CTL_LOAD_B];
                tmr.en_a   <= din[opn_pkg::CTL_EN_A];
                tmr.en_b   <= din[opn_pkg::CTL_EN_B];
                tmr.clr_a  <= din[opn_pkg::CTL_CLR_A];
                tmr.clr_b  <= din[opn_pkg::CTL_CLR_B];
            end
        end
    end

    // Busy drops once BUSY_CYCLES cen-high cycles have gone by
    a_busy_len: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> cen [->opn_pkg::BUSY_CYCLES] ##1 !busy)
        else $error("busy held past %0d cen cycles", opn_pkg::BUSY_CYCLES);

    // Busy keeps a second control write away, so clears never stretch
    a_clr_pulse: assert property (@(posedge clk) disable iff (rst)
        (tmr.clr_a || tmr.clr_b) |=> !(tmr.clr_a || tmr.clr_b))
        else $error("timer clear pulse longer than one cycle");

endmodule

// File: hdl/opn_timebase.sv
`timescale 1ns/1ps
// Sample timebase, divides cen into the internal clock enable and the sample tick
module opn_timebase (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic tick
);

    typedef logic [$clog2(opn_pkg::PRESCALE)-1:0] div_t;
    typedef logic [$clog2(opn_pkg::SLOTS)-1:0]    slot_t;

    div_t  div_cnt;
    slot_t slot_cnt;
    logic  clk_en;      // Internal clock enable, one per operator slot

    assign clk_en = cen & (div_cnt == div_t'(opn_pkg::PRESCALE - 1));

    // cen prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (cen) begin
            if (div_cnt == div_t'(opn_pkg::PRESCALE - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Slot counter, wraps once per sample
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (clk_en) begin
            if (slot_cnt == slot_t'(opn_pkg::SLOTS - 1)) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tick <= 1'b0;
        end else begin
            tick <= clk_en & (slot_cnt == slot_t'(opn_pkg::SLOTS - 1));  // Last slot
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (rst)
        tick |=> !tick)
        else $error("sample tick on two consecutive cycles");

endmodule

// File: hdl/opn_timer_ab.sv
`timescale 1ns/1ps
// Timers A and B with reload on overflow, gated flags and the interrupt line
module opn_timer_ab (
    input  logic        clk,
    input  logic        rst,
    input  logic        tick,
    output logic        irq_n,
    opn_timer_if.timers tmr
);

    typedef logic [$clog2(opn_pkg::TIMER_B_DIV)-1:0] bdiv_t;

    logic [opn_pkg::TIMER_A_W-1:0] cnt_a;
    logic [opn_pkg::TIMER_B_W-1:0] cnt_b;
    bdiv_t                         div_b;      // Timer B sub-prescaler
    logic                          load_a_d;
    logic                          load_b_d;
    logic                          start_a;
    logic                          start_b;
    logic                          step_b;
    logic                          ovf_a;
    logic                          ovf_b;

    // Rising edge of load restarts a timer
    assign start_a = tmr.load_a & ~load_a_d;
    assign start_b = tmr.load_b & ~load_b_d;

    assign ovf_a  = tmr.load_a & ~start_a & tick & (&cnt_a);
    assign step_b = tmr.load_b & ~start_b & tick
                  & (div_b == bdiv_t'(opn_pkg::TIMER_B_DIV - 1));
    assign ovf_b  = step_b & (&cnt_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a_d <= 1'b0;
            load_b_d <= 1'b0;
        end else begin
            load_a_d <= tmr.load_a;
            load_b_d <= tmr.load_b;
        end
    end

    // Timer A, one step per sample tick
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
        end else if (start_a || ovf_a) begin
            cnt_a <= tmr.value_a;
        end else if (tmr.load_a && tick) begin
            cnt_a <= cnt_a + 1'b1;
        end
    end

    // Timer B sub-prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            div_b <= '0;
        end else if (start_b) begin
            div_b <= '0;
        end else if (tmr.load_b && tick) begin
            if (div_b == bdiv_t'(opn_pkg::TIMER_B_DIV - 1)) begin
                div_b <= '0;
            end else begin
                div_b <= div_b + 1'b1;
            end
        end
    end

    // Timer B counter
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b <= '0;
        end else if (start_b || ovf_b) begin
            cnt_b <= tmr.value_b;
        end else if (step_b) begin
            cnt_b <= cnt_b + 1'b1;
        end
    end

    // Flags stay up until cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            tmr.flag_a <= 1'b0;
            tmr.flag_b <= 1'b0;
        end else begin
            if (tmr.clr_a) begin
                tmr.flag_a <= 1'b0;
            end
            if (ovf_a && tmr.en_a) begin
                tmr.flag_a <= 1'b1;     // A new overflow wins over a clear
            end
            if (tmr.clr_b) begin
                tmr.flag_b <= 1'b0;
            end
            if (ovf_b && tmr.en_b) begin
                tmr.flag_b <= 1'b1;
            end
        end
    end

    assign irq_n = ~(tmr.flag_a | tmr.flag_b);

    // Enable levels come from the decoder
    a_flag_a_gated: assert property (@(posedge clk) disable iff (rst)
        $rose(tmr.flag_a) |-> $past(tmr.en_a))
        else $error("flag A set while timer A disabled");

    a_flag_b_gated: assert property (@(posedge clk) disable iff (rst)
        $rose(tmr.flag_b) |-> $past(tmr.en_b))
        else $error("flag B set while timer B disabled");

endmodule

// File: hdl/opn_timer_top.sv
`timescale 1ns/1ps
// FM chip timer core top, CPU bus decoder, timebase and timers with status byte
module opn_timer_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,     // Clock enable, tie high if unused
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n
);

    logic busy;
    logic tick;     // Once per sample

    opn_timer_if tmr0 (
        .clk    ( clk   )
    );

    opn_reg_decode u_decode (
        .clk    ( clk           ),
        .rst    ( rst           ),
        .cen    ( cen           ),
        .din    ( din           ),
        .addr   ( addr          ),
        .cs_n   ( cs_n          ),
        .wr_n   ( wr_n          ),
        .busy   ( busy          ),
        .tmr    ( tmr0.decode   )
    );

    opn_timebase u_timebase (
        .clk    ( clk   ),
        .rst    ( rst   ),
        .cen    ( cen   ),
        .tick   ( tick  )
    );

    opn_timer_ab u_timers (
        .clk    ( clk           ),
        .rst    ( rst           ),
        .tick   ( tick          ),
        .irq_n  ( irq_n         ),
        .tmr    ( tmr0.timers   )
    );

    // Status byte, same at every address
    always_comb begin
        dout = 8'h00;
        dout[opn_pkg::STATUS_BUSY]   = busy;
        dout[opn_pkg::STATUS_FLAG_B] = tmr0.flag_b;
        dout[opn_pkg::STATUS_FLAG_A] = tmr0.flag_a;
    end

endmodule

// File: sim/opn_tb_model.svh
// Timer core reference model with expected registers, timer periods and the compare task
`ifndef OPN_TB_MODEL_SVH
`define OPN_TB_MODEL_SVH

    localparam int TICK_CYCLES = opn_pkg::PRESCALE * opn_pkg::SLOTS;  // cen-high cycles per sample

    logic [opn_pkg::TIMER_A_W-1:0] exp_value_a;
    logic [opn_pkg::TIMER_B_W-1:0] exp_value_b;
    int                            err_count;

    // Accepted data write, per the register map
    task automatic model_write(input logic [7:0] regnum, input logic [7:0] data);
        case (regnum)
            opn_pkg::REG_TIMER_A_HI: exp_value_a[opn_pkg::TIMER_A_W-1:2] = data;
            opn_pkg::REG_TIMER_A_LO: exp_value_a[1:0] = data[1:0];
            opn_pkg::REG_TIMER_B:    exp_value_b = data;
            default: ;
        endcase
    endtask

    function automatic logic [7:0] ctl_byte(input bit load_a, input bit load_b,
                                            input bit en_a, input bit en_b,
                                            input bit clr_a, input bit clr_b);
        logic [7:0] b;
        b = 8'h00;
        b[opn_pkg::CTL_LOAD_A] = load_a;
        b[opn_pkg::CTL_LOAD_B] = load_b;
        b[opn_pkg::CTL_EN_A]   = en_a;
        b[opn_pkg::CTL_EN_B]   = en_b;
        b[opn_pkg::CTL_CLR_A]  = clr_a;
        b[opn_pkg::CTL_CLR_B]  = clr_b;
        return b;
    endfunction

    // Timer A counts from value up to all ones
    function automatic int period_a_cycles();
        return ((1 << opn_pkg::TIMER_A_W) - int'(exp_value_a)) * TICK_CYCLES;
    endfunction

    function automatic int period_b_cycles();
        return opn_pkg::TIMER_B_DIV * ((1 << opn_pkg::TIMER_B_W) - int'(exp_value_b))
               * TICK_CYCLES;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("mismatch at %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

`endif

// File: sim/opn_tb.sv
`timescale 1ns/1ps
// Testbench for the FM chip timer core covering bus writes, busy timing and timer periods
module opn_tb;

    logic       clk;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    integer     seed;
    longint     cen_count;      // cen-high edges since reset
    longint     cen_prev;       // cen_count one edge back
    int         rises_a;
    int         rises_b;
    longint     rise_a_at;
    longint     rise_b_at;
    logic       prev_a;
    logic       prev_b;
    int         pass_tests;
    int         fail_tests;
    int         test_errs;
    logic [9:0] va;
    logic [7:0] vb;
    int         cycles;
    longint     gap;

    `include "opn_tb_model.svh"

    localparam int CLK_PERIOD = 10;
    localparam int MAX_A      = 24 * TICK_CYCLES;                           // value_a 1000
    localparam int MAX_B      = opn_pkg::TIMER_B_DIV * 6 * TICK_CYCLES;     // value_b 250
    // Timer B, timer A, masking, then timer A at half-rate cen
    localparam int WATCHDOG_CYCLES = 2 * MAX_B + 2 * MAX_A + 2 * MAX_A + 4 * MAX_A + 5000;

    opn_timer_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Flag rise times in cen-high cycles and the irq_n cross-check
    always @(posedge clk) begin
        if (rst) begin
            cen_count = 0;
            cen_prev  = 0;
            rises_a   = 0;
            rises_b   = 0;
            prev_a    = 1'b0;
            prev_b    = 1'b0;
        end else begin
            // A rise shows two edges after the cen-high edge that ends the sample
            if (dout[opn_pkg::STATUS_FLAG_A] && !prev_a) begin
                rises_a++;
                rise_a_at = cen_prev;
            end
            if (dout[opn_pkg::STATUS_FLAG_B] && !prev_b) begin
                rises_b++;
                rise_b_at = cen_prev;
            end
            check("irq_n", !(dout[opn_pkg::STATUS_FLAG_A] || dout[opn_pkg::STATUS_FLAG_B]),
                  irq_n);
            prev_a   = dout[opn_pkg::STATUS_FLAG_A];
            prev_b   = dout[opn_pkg::STATUS_FLAG_B];
            cen_prev = cen_count;
            if (cen) cen_count++;
        end
    end

    task automatic wait_busy_low(output int n);
        n = 0;
        while (dout[opn_pkg::STATUS_BUSY] === 1'b1 && n < 4 * opn_pkg::BUSY_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (dout[opn_pkg::STATUS_BUSY] !== 1'b0) begin
            err_count++;
            $display("busy bit still high %0d cycles after a write at %0t", n, $time);
        end
    endtask

    // Address cycle followed by the data cycle
    task automatic write_reg(input logic [7:0] regnum, input logic [7:0] data,
                             input bit wait_idle);
        int n;
        cen  = 1'b1;
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;
        din  = regnum;
        @(posedge clk);
        #1;
        addr = 2'b01;
        din  = data;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 2'b00;
        if (wait_idle) wait_busy_low(n);
    endtask

    task automatic wait_flag_rise(input bit is_b, input int target, input int limit,
                                  input bit rand_cen);
        int n;
        int rnd;
        n = 0;
        while ((is_b ? rises_b : rises_a) < target && n < limit) begin
            @(posedge clk);
            #1;
            if (rand_cen) begin
                rnd = $random(seed);
                cen = rnd[0];       // About half the cycles
            end
            n++;
        end
        if ((is_b ? rises_b : rises_a) < target) begin
            err_count++;
            $display("timer %s flag did not rise within %0d cycles", is_b ? "B" : "A", limit);
        end
    endtask

    // First rise, clear, then the next rise
    task automatic measure_gap(input bit is_b, input bit rand_cen, input logic [7:0] clear_ctl,
                               output longint gap_out);
        int     limit;
        int     first;
        longint t_first;
        limit = (is_b ? period_b_cycles() : period_a_cycles()) * (rand_cen ? 4 : 2) + 500;
        first = (is_b ? rises_b : rises_a) + 1;
        wait_flag_rise(is_b, first, limit, rand_cen);
        t_first = is_b ? rise_b_at : rise_a_at;
        write_reg(opn_pkg::REG_TIMER_CTL, clear_ctl, 1'b1);
        check(is_b ? "flag_b" : "flag_a", 0,
              dout[is_b ? opn_pkg::STATUS_FLAG_B : opn_pkg::STATUS_FLAG_A]);
        wait_flag_rise(is_b, first + 1, limit, rand_cen);
        check("irq_n", 0, irq_n);
        gap_out = (is_b ? rise_b_at : rise_a_at) - t_first;
    endtask

    task automatic start_test();
        test_errs = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_errs) begin
            pass_tests++;
            $display("test %s passed", name);
        end else begin
            fail_tests++;
            $display("test %s failed with %0d errors", name, err_count - test_errs);
        end
    endtask

    task automatic write_value_a(input logic [9:0] value);
        write_reg(opn_pkg::REG_TIMER_A_HI, value[9:2], 1'b1);
        model_write(opn_pkg::REG_TIMER_A_HI, value[9:2]);
        write_reg(opn_pkg::REG_TIMER_A_LO, {6'd0, value[1:0]}, 1'b1);
        model_write(opn_pkg::REG_TIMER_A_LO, {6'd0, value[1:0]});
    endtask

    initial begin
        seed        = 91086;
        rst         = 1'b1;
        cen         = 1'b1;
        din         = 8'h00;
        addr        = 2'b00;
        cs_n        = 1'b1;
        wr_n        = 1'b1;
        exp_value_a = '0;
        exp_value_b = '0;
        err_count   = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        check("dout", 8'h00, dout);
        check("irq_n", 1, irq_n);
        end_test("reset");

        // Second timer B value lands while busy and is lost
        start_test();
        vb = 8'd250 + 8'($unsigned($random(seed)) % 6);
        write_reg(opn_pkg::REG_TIMER_B, vb, 1'b0);
        model_write(opn_pkg::REG_TIMER_B, vb);
        check("dout", 1 << opn_pkg::STATUS_BUSY, dout);
        write_reg(opn_pkg::REG_TIMER_B, 8'd250 + 8'((vb - 8'd247) % 6), 1'b0);
        wait_busy_low(cycles);
        check("busy_cycles", opn_pkg::BUSY_CYCLES, cycles + 2);
        end_test("busy");

        start_test();
        write_reg(opn_pkg::REG_TIMER_CTL, ctl_byte(0, 1, 0, 1, 0, 0), 1'b1);
        measure_gap(1'b1, 1'b0, ctl_byte(0, 1, 0, 1, 0, 1), gap);
        check("flag_b_gap", period_b_cycles(), gap);
        end_test("timer_b");

        start_test();
        va = 10'd1000 + 10'($unsigned($random(seed)) % 21);
        write_value_a(va);
        write_reg(opn_pkg::REG_TIMER_CTL, ctl_byte(1, 0, 1, 0, 0, 0), 1'b1);
        measure_gap(1'b0, 1'b0, ctl_byte(1, 0, 1, 0, 1, 0), gap);
        check("flag_a_gap", period_a_cycles(), gap);
        end_test("timer_a");

        // Both flags up on entry
        start_test();
        write_reg(opn_pkg::REG_TIMER_CTL, ctl_byte(1, 0, 0, 0, 1, 1), 1'b1);
        check("dout", 8'h00, dout);
        check("irq_n", 1, irq_n);
        cycles = rises_a;
        repeat (2 * period_a_cycles()) @(posedge clk);
        #1;
        check("flag_a_rises", cycles, rises_a);
        check("dout", 8'h00, dout);
        end_test("mask_clear");

        start_test();
        va = 10'd1000 + 10'($unsigned($random(seed)) % 21);
        write_value_a(va);
        write_reg(opn_pkg::REG_TIMER_CTL, ctl_byte(1, 0, 1, 0, 1, 0), 1'b1);
        measure_gap(1'b0, 1'b1, ctl_byte(1, 0, 1, 0, 1, 0), gap);
        cen = 1'b1;
        check("flag_a_gap", period_a_cycles(), gap);
        end_test("cen_throttle");

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: opn_timers.f
+incdir+sim
hdl/opn_pkg.sv
hdl/opn_timer_if.sv
hdl/opn_reg_decode.sv
hdl/opn_timebase.sv
hdl/opn_timer_ab.sv
hdl/opn_timer_top.sv
sim/opn_tb.sv
